// ==== src.f ====
+incdir+dv
verilog/mpa_pkg.sv
verilog/mpa_issue_if.sv
verilog/mpa_issue.sv
verilog/mpa_malu.sv
verilog/mpa_cpr.sv
verilog/mpa_top.sv
dv/mpa_tb.sv

// ==== Bender.yml ====
package:
  name: mpa_coproc

sources:
  - files:
      - verilog/mpa_pkg.sv
      - verilog/mpa_issue_if.sv
      - verilog/mpa_issue.sv
      - verilog/mpa_malu.sv
      - verilog/mpa_cpr.sv
      - verilog/mpa_top.sv

  - target: test
    include_dirs:
      - dv
    files:
      - dv/mpa_tb.sv

// ==== dv/mpa_model.svh ====
////////////////////////////////////////////////////////////////////////////
// Reference model of the coprocessor operations and a shadow register file
////////////////////////////////////////////////////////////////////////////

`ifndef MPA_MODEL_SVH
`define MPA_MODEL_SVH

logic [MPA_XLEN-1:0] shadow [MPA_NUM_CPR];

function automatic logic [63:0] carryless_product(
    input logic [31:0] a,
    input logic [31:0] b
);
    logic [63:0] acc;
    acc = '0;
    for (int i = 0; i < 32; i++) begin
        if (a[i]) begin
            acc = acc ^ ({32'b0, b} << i);
        end
    end
    return acc;
endfunction

// Full 64-bit result; compares return 0 or 1
function automatic logic [63:0] op_result(
    input mpa_subclass_e sc,
    input logic [31:0]   a,
    input logic [31:0]   b,
    input logic [31:0]   c,
    input logic [5:0]    imm,
    input logic [31:0]   gpr
);
    logic [63:0] pair;
    logic        chain;
    pair  = {a, b};
    chain = (b == c) && (gpr != 32'd0);
    case (sc)
        MPA_SC_MADD_2:   return {32'b0, a} + {32'b0, b};
        MPA_SC_MADD_3:   return {32'b0, a} + {32'b0, b} + {32'b0, c};
        MPA_SC_MSUB_2:   return {32'b0, a} - {32'b0, b};
        MPA_SC_MSUB_3:   return {32'b0, a} - {32'b0, b} - {32'b0, c};
        MPA_SC_MACC_1:   return {b, c} + {32'b0, a};
        MPA_SC_MMUL_1:   return {32'b0, a} * {32'b0, b} + {32'b0, c};
        MPA_SC_MCLMUL_1: return carryless_product(a, b) ^ {32'b0, c};
        MPA_SC_MSLL_I:   return pair << imm;
        MPA_SC_MSRL_I:   return pair >> imm;
        MPA_SC_MSLL:     return (c >= 32'd64) ? 64'd0 : pair << c;
        MPA_SC_MSRL:     return (c >= 32'd64) ? 64'd0 : pair >> c;
        MPA_SC_MEQU:     return {63'd0, chain};
        MPA_SC_MLTE:     return {63'd0, chain || (b < c)};
        MPA_SC_MGTE:     return {63'd0, chain || (b > c)};
        default:         return 64'd0;
    endcase
endfunction

function automatic int expected_last_step(input mpa_subclass_e sc);
    case (sc)
        MPA_SC_MEQU, MPA_SC_MLTE, MPA_SC_MGTE:     return 0;
        MPA_SC_MADD_3, MPA_SC_MSUB_3, MPA_SC_MMUL_1: return 2;
        default:                                    return 1;
    endcase
endfunction

// Three-step ops only load temp in step 0
function automatic bit writes_in_first_step(input mpa_subclass_e sc);
    return !(sc inside {MPA_SC_MADD_3, MPA_SC_MSUB_3, MPA_SC_MMUL_1});
endfunction

function automatic bit writes_one_word(input mpa_subclass_e sc);
    return sc inside {MPA_SC_MEQU, MPA_SC_MLTE, MPA_SC_MGTE};
endfunction

task automatic update_shadow(
    input mpa_instr_t  ins,
    input logic [31:0] gpr,
    input logic        hwe,
    input logic [2:0]  haddr,
    input logic [31:0] hdata
);
    logic [63:0] res;
    logic [2:0]  hi_addr;
    res = op_result(ins.subclass, shadow[ins.crs1], shadow[ins.crs2],
                    shadow[ins.crs3], ins.imm, gpr);
    hi_addr = ins.crd + 3'd1;
    // Host write in the first busy cycle loses to a step 0 writeback
    if (hwe && !writes_in_first_step(ins.subclass)) begin
        shadow[haddr] = hdata;
    end
    shadow[ins.crd] = res[31:0];
    if (!writes_one_word(ins.subclass)) begin
        shadow[hi_addr] = res[63:32];
    end
endtask

`endif

// ==== dv/mpa_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// Coprocessor slice testbench with random instructions checked against a model
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module mpa_tb import mpa_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    logic                  g_clk;
    logic                  g_resetn;
    logic                  instr_valid_i;
    logic                  instr_ready_o;
    mpa_instr_t            instr_i;
    logic [MPA_XLEN-1:0]   gpr_rs1_i;
    logic                  cpr_we_i;
    logic [MPA_CPR_AW-1:0] cpr_waddr_i;
    logic [MPA_XLEN-1:0]   cpr_wdata_i;
    logic [MPA_CPR_AW-1:0] cpr_raddr_i;
    logic [MPA_XLEN-1:0]   cpr_rdata_o;

    integer seed;
    int     errors;
    int     checks;
    bit     timed_out;

    `include "mpa_model.svh"

    mpa_top dut (
        .g_clk         (g_clk),
        .g_resetn      (g_resetn),
        .instr_valid_i (instr_valid_i),
        .instr_ready_o (instr_ready_o),
        .instr_i       (instr_i),
        .gpr_rs1_i     (gpr_rs1_i),
        .cpr_we_i      (cpr_we_i),
        .cpr_waddr_i   (cpr_waddr_i),
        .cpr_wdata_i   (cpr_wdata_i),
        .cpr_raddr_i   (cpr_raddr_i),
        .cpr_rdata_o   (cpr_rdata_o)
    );

    initial begin
        g_clk = 1'b0;
        forever #50 g_clk = ~g_clk;
    end

    task automatic host_write(input logic [2:0] addr, input logic [31:0] data);
        @(negedge g_clk);
        cpr_we_i    = 1'b1;
        cpr_waddr_i = addr;
        cpr_wdata_i = data;
        @(negedge g_clk);
        cpr_we_i     = 1'b0;
        shadow[addr] = data;
    endtask

    // Reads the whole file through the combinational host port
    task automatic check_regs(input string name);
        for (int r = 0; r < MPA_NUM_CPR; r++) begin
            @(negedge g_clk);
            cpr_raddr_i = r[2:0];
            @(negedge g_clk);
            checks++;
            if (cpr_rdata_o !== shadow[r]) begin
                errors++;
                $display("[ERROR] %s: cpr[%0d] expected %08h actual %08h",
                         name, r, shadow[r], cpr_rdata_o);
            end
        end
    endtask

    task automatic drive_instr(
        input  mpa_instr_t  ins,
        input  logic [31:0] gpr,
        input  logic        hwe,
        input  logic [2:0]  haddr,
        input  logic [31:0] hdata,
        output int          low_cycles
    );
        @(negedge g_clk);
        instr_valid_i = 1'b1;
        instr_i       = ins;
        gpr_rs1_i     = gpr;
        // First busy cycle after the accept edge
        @(negedge g_clk);
        cpr_we_i    = hwe;
        cpr_waddr_i = haddr;
        cpr_wdata_i = hdata;
        low_cycles  = 0;
        while (!instr_ready_o && low_cycles < 20) begin
            low_cycles++;
            // Junk offers while busy
            instr_i   = mpa_instr_t'($random(seed));
            gpr_rs1_i = $random(seed);
            @(negedge g_clk);
            cpr_we_i = 1'b0;
        end
        instr_valid_i = 1'b0;
        cpr_we_i      = 1'b0;
    endtask

    task automatic issue_random();
        mpa_instr_t  ins;
        logic [31:0] gpr;
        logic        hwe;
        logic [2:0]  haddr;
        logic [31:0] hdata;
        logic [31:0] small_amt;
        int          pick;
        int          low_cycles;
        string       name;
        ins          = '0;
        ins.subclass = mpa_subclass_e'($unsigned($random(seed)) % 14);
        ins.crd      = MPA_CPR_AW'($random(seed));
        ins.crs1     = MPA_CPR_AW'($random(seed));
        ins.crs2     = MPA_CPR_AW'($random(seed));
        ins.crs3     = MPA_CPR_AW'($random(seed));
        ins.imm      = MPA_IMM_W'($random(seed));
        gpr          = $random(seed);
        name         = ins.subclass.name();
        if (($random(seed) & 1) != 0) begin
            gpr = '0;
        end
        if (writes_one_word(ins.subclass) && ($random(seed) & 3) == 0) begin
            ins.crs3 = ins.crs2;
        end
        // Register shift amounts below 64 half of the time
        if (ins.subclass inside {MPA_SC_MSLL, MPA_SC_MSRL} && ($random(seed) & 1) != 0) begin
            small_amt = $random(seed) & 63;
            host_write(ins.crs3, small_amt);
        end
        hwe   = ($unsigned($random(seed)) % 3) == 0;
        pick  = $unsigned($random(seed)) % 3;
        haddr = (pick == 0) ? ins.crs1 : (pick == 1) ? ins.crs2 : ins.crs3;
        hdata = $random(seed);

        drive_instr(ins, gpr, hwe, haddr, hdata, low_cycles);
        if (!instr_ready_o) begin
            timed_out = 1'b1;
            errors++;
            $display("Timeout: instr_ready_o did not return high within 20 cycles (%s)",
                     name);
        end else begin
            checks++;
            if (low_cycles != expected_last_step(ins.subclass) + 1) begin
                errors++;
                $display("[ERROR] %s ready-low cycles: expected %0d actual %0d", name,
                         expected_last_step(ins.subclass) + 1, low_cycles);
            end
            update_shadow(ins, gpr, hwe, haddr, hdata);
            check_regs(name);
        end
    endtask

    initial begin
        seed          = 53;
        errors        = 0;
        checks        = 0;
        timed_out     = 1'b0;
        g_resetn      = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        gpr_rs1_i     = '0;
        cpr_we_i      = 1'b0;
        cpr_waddr_i   = '0;
        cpr_wdata_i   = '0;
        cpr_raddr_i   = '0;
        for (int r = 0; r < MPA_NUM_CPR; r++) begin
            shadow[r] = '0;
        end

        repeat (4) @(negedge g_clk);
        g_resetn = 1'b1;
        @(negedge g_clk);
        checks++;
        if (instr_ready_o !== 1'b1) begin
            errors++;
            $display("[ERROR] reset_ready: expected 1 actual %b", instr_ready_o);
        end
        check_regs("reset");

        for (int r = 0; r < MPA_NUM_CPR; r++) begin
            host_write(r[2:0], $random(seed));
        end
        check_regs("preload");

        for (int n = 0; n < 400 && !timed_out; n++) begin
            issue_random();
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/mpa_top.sv ====
////////////////////////////////////////////////////////////////////////////
// Multi-precision coprocessor slice: issue, ALU and register file
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module mpa_top import mpa_pkg::*; (
    input  logic                  g_clk,
    input  logic                  g_resetn,

    input  logic                  instr_valid_i,
    output logic                  instr_ready_o,
    input  mpa_instr_t            instr_i,
    input  logic [MPA_XLEN-1:0]   gpr_rs1_i,

    input  logic                  cpr_we_i,
    input  logic [MPA_CPR_AW-1:0] cpr_waddr_i,
    input  logic [MPA_XLEN-1:0]   cpr_wdata_i,
    input  logic [MPA_CPR_AW-1:0] cpr_raddr_i,
    output logic [MPA_XLEN-1:0]   cpr_rdata_o
);

    mpa_issue_if issue_bus ();

    logic [MPA_CPR_AW-1:0] rd_addr1, rd_addr2, rd_addr3;
    logic [MPA_XLEN-1:0]   rd_data1, rd_data2, rd_data3;
    logic                  wb_en;
    logic [MPA_CPR_AW-1:0] wb_addr;
    logic [MPA_XLEN-1:0]   wb_data;

    mpa_issue u_issue (
        .g_clk         (g_clk),
        .g_resetn      (g_resetn),
        .instr_valid_i (instr_valid_i),
        .instr_ready_o (instr_ready_o),
        .instr_i       (instr_i),
        .gpr_rs1_i     (gpr_rs1_i),
        .rd_addr1_o    (rd_addr1),
        .rd_addr2_o    (rd_addr2),
        .rd_addr3_o    (rd_addr3),
        .rd_data1_i    (rd_data1),
        .rd_data2_i    (rd_data2),
        .rd_data3_i    (rd_data3),
        .issue_o       (issue_bus.issue)
    );

    mpa_malu u_malu (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .issue_i   (issue_bus.alu),
        .wb_en_o   (wb_en),
        .wb_addr_o (wb_addr),
        .wb_data_o (wb_data)
    );

    mpa_cpr u_cpr (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .rd_addr1_i   (rd_addr1),
        .rd_addr2_i   (rd_addr2),
        .rd_addr3_i   (rd_addr3),
        .rd_data1_o   (rd_data1),
        .rd_data2_o   (rd_data2),
        .rd_data3_o   (rd_data3),
        .wb_en_i      (wb_en),
        .wb_addr_i    (wb_addr),
        .wb_data_i    (wb_data),
        .host_we_i    (cpr_we_i),
        .host_waddr_i (cpr_waddr_i),
        .host_wdata_i (cpr_wdata_i),
        .host_raddr_i (cpr_raddr_i),
        .host_rdata_o (cpr_rdata_o)
    );

endmodule

`default_nettype wire

// ==== verilog/mpa_cpr.sv ====
////////////////////////////////////////////////////////////////////////////
// Coprocessor register file: eight words, ALU writeback over host write
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module mpa_cpr import mpa_pkg::*; (
    input  logic                  g_clk,
    input  logic                  g_resetn,

    input  logic [MPA_CPR_AW-1:0] rd_addr1_i,
    input  logic [MPA_CPR_AW-1:0] rd_addr2_i,
    input  logic [MPA_CPR_AW-1:0] rd_addr3_i,
    output logic [MPA_XLEN-1:0]   rd_data1_o,
    output logic [MPA_XLEN-1:0]   rd_data2_o,
    output logic [MPA_XLEN-1:0]   rd_data3_o,

    input  logic                  wb_en_i,
    input  logic [MPA_CPR_AW-1:0] wb_addr_i,
    input  logic [MPA_XLEN-1:0]   wb_data_i,

    input  logic                  host_we_i,
    input  logic [MPA_CPR_AW-1:0] host_waddr_i,
    input  logic [MPA_XLEN-1:0]   host_wdata_i,
    input  logic [MPA_CPR_AW-1:0] host_raddr_i,
    output logic [MPA_XLEN-1:0]   host_rdata_o
);

    logic [MPA_XLEN-1:0] regs [MPA_NUM_CPR];

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int i = 0; i < MPA_NUM_CPR; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en_i) begin
            regs[wb_addr_i] <= wb_data_i;
        end else if (host_we_i) begin
            // Host write only lands when the ALU is not writing
            regs[host_waddr_i] <= host_wdata_i;
        end
    end

    assign rd_data1_o   = regs[rd_addr1_i];
    assign rd_data2_o   = regs[rd_addr2_i];
    assign rd_data3_o   = regs[rd_addr3_i];
    assign host_rdata_o = regs[host_raddr_i];

endmodule

`default_nettype wire

// ==== verilog/mpa_malu.sv ====
////////////////////////////////////////////////////////////////////////////
// Multi-precision ALU: steps each instruction through the adder, multipliers,
// shifter and comparator and writes back one word per cycle
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module mpa_malu import mpa_pkg::*; (
    input  logic                  g_clk,
    input  logic                  g_resetn,

    mpa_issue_if.alu              issue_i,

    output logic                  wb_en_o,
    output logic [MPA_CPR_AW-1:0] wb_addr_o,
    output logic [MPA_XLEN-1:0]   wb_data_o
);

    // Per-instruction decode
    logic is_mequ, is_mlte, is_mgte;
    logic is_madd_3, is_madd_2, is_msub_3, is_msub_2, is_macc_1;
    logic is_msll_i, is_msll, is_msrl_i, is_msrl;
    logic is_mmul_1, is_mclmul_1;

    assign is_mequ     = issue_i.valid && (issue_i.subclass == MPA_SC_MEQU);
    assign is_mlte     = issue_i.valid && (issue_i.subclass == MPA_SC_MLTE);
    assign is_mgte     = issue_i.valid && (issue_i.subclass == MPA_SC_MGTE);
    assign is_madd_3   = issue_i.valid && (issue_i.subclass == MPA_SC_MADD_3);
    assign is_madd_2   = issue_i.valid && (issue_i.subclass == MPA_SC_MADD_2);
    assign is_msub_3   = issue_i.valid && (issue_i.subclass == MPA_SC_MSUB_3);
    assign is_msub_2   = issue_i.valid && (issue_i.subclass == MPA_SC_MSUB_2);
    assign is_macc_1   = issue_i.valid && (issue_i.subclass == MPA_SC_MACC_1);
    assign is_msll_i   = issue_i.valid && (issue_i.subclass == MPA_SC_MSLL_I);
    assign is_msll     = issue_i.valid && (issue_i.subclass == MPA_SC_MSLL);
    assign is_msrl_i   = issue_i.valid && (issue_i.subclass == MPA_SC_MSRL_I);
    assign is_msrl     = issue_i.valid && (issue_i.subclass == MPA_SC_MSRL);
    assign is_mmul_1   = issue_i.valid && (issue_i.subclass == MPA_SC_MMUL_1);
    assign is_mclmul_1 = issue_i.valid && (issue_i.subclass == MPA_SC_MCLMUL_1);

    // Operation groups sharing one step schedule
    logic is_cmp, is_add2, is_add3, is_shf;

    assign is_cmp  = is_mequ || is_mlte || is_mgte;
    assign is_add2 = is_madd_2 || is_msub_2 || is_macc_1;
    assign is_add3 = is_madd_3 || is_msub_3;
    assign is_shf  = is_msll_i || is_msll || is_msrl_i || is_msrl;

    // Step counter
    mpa_step_t step;
    logic      step0, step1, step2;

    assign step0 = (step == 2'd0);
    assign step1 = (step == 2'd1);
    assign step2 = (step == 2'd2);

    assign issue_i.done = issue_i.valid && (step == MPA_LAST_STEP[issue_i.subclass]);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            step <= '0;
        end else if (issue_i.done) begin
            step <= '0;
        end else if (issue_i.valid) begin
            step <= step + 2'd1;
        end
    end

    // Unit results
    logic [MPA_DXLEN-1:0] result_add;
    logic [MPA_DXLEN-1:0] result_mul;
    logic [MPA_DXLEN-1:0] result_clmul;
    logic [MPA_DXLEN-1:0] result_shf;
    logic                 result_cmp;

    // Temporary register
    logic [MPA_DXLEN-1:0] tmp;
    logic tmp_ld_add, tmp_ld_mul, tmp_ld_clmul, tmp_ld_shf;

    assign tmp_ld_add   = step0 && (is_add2 || is_add3) || step1 && (is_add3 || is_mmul_1);
    assign tmp_ld_mul   = step0 && is_mmul_1;
    assign tmp_ld_clmul = step0 && is_mclmul_1;
    assign tmp_ld_shf   = step0 && is_shf;

    always_ff @(posedge g_clk) begin
        if (tmp_ld_add) begin
            tmp <= result_add;
        end else if (tmp_ld_mul) begin
            tmp <= result_mul;
        end else if (tmp_ld_clmul) begin
            tmp <= result_clmul;
        end else if (tmp_ld_shf) begin
            tmp <= result_shf;
        end
    end

    // 64-bit adder, operands picked per step
    logic                 add_lhs_rs1, add_lhs_tmp;
    logic                 add_rhs_rs2, add_rhs_rs3, add_rhs_r23;
    logic                 do_sub;
    logic [MPA_DXLEN-1:0] add_lhs, add_rhs;

    assign add_lhs_rs1 = step0 && (is_add2 || is_add3);
    assign add_lhs_tmp = step1 && (is_add3 || is_mmul_1);
    assign add_rhs_rs2 = step0 && (is_madd_2 || is_msub_2 || is_add3);
    assign add_rhs_rs3 = step1 && (is_add3 || is_mmul_1);
    assign add_rhs_r23 = step0 && is_macc_1;
    assign do_sub      = is_msub_2 || is_msub_3;

    assign add_lhs = {MPA_DXLEN{add_lhs_rs1}} & {{MPA_XLEN{1'b0}}, issue_i.rs1}
                   | {MPA_DXLEN{add_lhs_tmp}} & tmp;

    assign add_rhs = {MPA_DXLEN{add_rhs_rs2}} & {{MPA_XLEN{1'b0}}, issue_i.rs2}
                   | {MPA_DXLEN{add_rhs_rs3}} & {{MPA_XLEN{1'b0}}, issue_i.rs3}
                   | {MPA_DXLEN{add_rhs_r23}} & {issue_i.rs2, issue_i.rs3};

    assign result_add = do_sub ? add_lhs - add_rhs : add_lhs + add_rhs;

    // 32x32 multiplier, inputs held at zero when idle
    logic [MPA_XLEN-1:0] mul_lhs, mul_rhs;

    assign mul_lhs    = {MPA_XLEN{tmp_ld_mul}} & issue_i.rs1;
    assign mul_rhs    = {MPA_XLEN{tmp_ld_mul}} & issue_i.rs2;
    assign result_mul = MPA_DXLEN'(mul_lhs) * MPA_DXLEN'(mul_rhs);

    // 32x32 carry-less multiplier
    logic [MPA_XLEN-1:0]  clmul_lhs, clmul_rhs;
    logic [MPA_DXLEN-1:0] clmul_acc;

    assign clmul_lhs = {MPA_XLEN{tmp_ld_clmul}} & issue_i.rs1;
    assign clmul_rhs = {MPA_XLEN{tmp_ld_clmul}} & issue_i.rs2;

    always_comb begin
        clmul_acc = '0;
        for (int i = 0; i < MPA_XLEN; i++) begin
            if (clmul_rhs[i]) begin
                clmul_acc = clmul_acc ^ (MPA_DXLEN'(clmul_lhs) << i);
            end
        end
    end

    assign result_clmul = clmul_acc ^ {{MPA_XLEN{1'b0}}, issue_i.rs3};

    // 64-bit funnel shifter over {rs1,rs2}
    logic                 shf_right, shf_by_imm, shf_zero;
    logic [MPA_IMM_W-1:0] shamt;
    logic [MPA_DXLEN-1:0] shf_in;

    assign shf_right  = is_msrl || is_msrl_i;
    assign shf_by_imm = is_msrl_i || is_msll_i;
    assign shamt      = shf_by_imm ? issue_i.imm : issue_i.rs3[MPA_IMM_W-1:0];
    // Register amounts of 64 or more clear the result
    assign shf_zero   = (is_msrl || is_msll) && |issue_i.rs3[MPA_XLEN-1:MPA_IMM_W];
    assign shf_in     = {MPA_DXLEN{is_shf}} & {issue_i.rs1, issue_i.rs2};

    assign result_shf = shf_zero  ? '0 :
                        shf_right ? shf_in >> shamt :
                                    shf_in << shamt;

    // Chained comparator, rs2 against rs3
    logic [MPA_XLEN-1:0] cmp_lhs, cmp_rhs;
    logic                cmp_eq, cmp_lt, chain_eq;

    assign cmp_lhs  = {MPA_XLEN{is_cmp}} & issue_i.rs2;
    assign cmp_rhs  = {MPA_XLEN{is_cmp}} & issue_i.rs3;
    assign cmp_eq   = (cmp_lhs == cmp_rhs);
    assign cmp_lt   = (cmp_lhs < cmp_rhs);
    // Equal words only count when the previous limb said so
    assign chain_eq = cmp_eq && |issue_i.gpr;

    assign result_cmp = is_mequ && chain_eq
                     || is_mlte && (chain_eq || cmp_lt)
                     || is_mgte && (chain_eq || !(cmp_lt || cmp_eq));

    // Writeback selection
    logic wb_add_lo, wb_shf_lo, wb_clmul_lo, wb_cmp, wb_tmp_hi;

    assign wb_add_lo   = step0 && is_add2 || step1 && (is_add3 || is_mmul_1);
    assign wb_shf_lo   = step0 && is_shf;
    assign wb_clmul_lo = step0 && is_mclmul_1;
    assign wb_cmp      = step0 && is_cmp;
    assign wb_tmp_hi   = step1 && (is_add2 || is_shf || is_mclmul_1)
                      || step2 && (is_add3 || is_mmul_1);

    assign wb_en_o   = wb_add_lo || wb_shf_lo || wb_clmul_lo || wb_cmp || wb_tmp_hi;
    assign wb_addr_o = wb_tmp_hi ? MPA_CPR_AW'(issue_i.crd + 1'b1) : issue_i.crd;

    assign wb_data_o = {MPA_XLEN{wb_add_lo}}   & result_add[MPA_XLEN-1:0]
                     | {MPA_XLEN{wb_shf_lo}}   & result_shf[MPA_XLEN-1:0]
                     | {MPA_XLEN{wb_clmul_lo}} & result_clmul[MPA_XLEN-1:0]
                     | {MPA_XLEN{wb_tmp_hi}}   & tmp[MPA_DXLEN-1:MPA_XLEN]
                     | {MPA_XLEN{wb_cmp}}      & {{(MPA_XLEN-1){1'b0}}, result_cmp};

    a_step_bound: assert property (
        @(posedge g_clk) disable iff (!g_resetn)
        step != 2'd3
    );

    // Issue side must hold the instruction until it completes
    a_issue_hold: assert property (
        @(posedge g_clk) disable iff (!g_resetn)
        issue_i.valid && !issue_i.done
        |=> issue_i.valid && $stable(issue_i.subclass) && $stable(issue_i.crd)
    );

endmodule

`default_nettype wire

// ==== verilog/mpa_issue.sv ====
////////////////////////////////////////////////////////////////////////////
// Issue stage: accepts an instruction, reads its operands and holds them
// stable for the ALU until the instruction completes
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module mpa_issue import mpa_pkg::*; (
    input  logic                  g_clk,
    input  logic                  g_resetn,

    input  logic                  instr_valid_i,
    output logic                  instr_ready_o,
    input  mpa_instr_t            instr_i,
    input  logic [MPA_XLEN-1:0]   gpr_rs1_i,

    output logic [MPA_CPR_AW-1:0] rd_addr1_o,
    output logic [MPA_CPR_AW-1:0] rd_addr2_o,
    output logic [MPA_CPR_AW-1:0] rd_addr3_o,
    input  logic [MPA_XLEN-1:0]   rd_data1_i,
    input  logic [MPA_XLEN-1:0]   rd_data2_i,
    input  logic [MPA_XLEN-1:0]   rd_data3_i,

    mpa_issue_if.issue            issue_o
);

    logic busy;
    logic accept;

    assign instr_ready_o = !busy;
    assign accept        = instr_valid_i && instr_ready_o;

    // Source reads happen in the accept cycle
    assign rd_addr1_o = instr_i.crs1;
    assign rd_addr2_o = instr_i.crs2;
    assign rd_addr3_o = instr_i.crs3;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            busy <= 1'b0;
        end else if (accept) begin
            busy <= 1'b1;
        end else if (issue_o.done) begin
            busy <= 1'b0;
        end
    end

    // Operand capture, so later CPR writes cannot disturb the instruction
    always_ff @(posedge g_clk) begin
        if (accept) begin
            issue_o.subclass <= instr_i.subclass;
            issue_o.imm      <= instr_i.imm;
            issue_o.crd      <= instr_i.crd;
            issue_o.rs1      <= rd_data1_i;
            issue_o.rs2      <= rd_data2_i;
            issue_o.rs3      <= rd_data3_i;
            issue_o.gpr      <= gpr_rs1_i;
        end
    end

    assign issue_o.valid = busy;

    // An offer while busy leaves the held instruction untouched
    a_offer_while_busy: assert property (
        @(posedge g_clk) disable iff (!g_resetn)
        instr_valid_i && !instr_ready_o && !issue_o.done
        |=> busy && $stable(issue_o.subclass) && $stable(issue_o.crd)
            && $stable(issue_o.rs1) && $stable(issue_o.rs2) && $stable(issue_o.rs3)
    );

endmodule

`default_nettype wire

// ==== verilog/mpa_issue_if.sv ====
////////////////////////////////////////////////////////////////////////////
// Issue interface: decoded instruction with captured operands
////////////////////////////////////////////////////////////////////////////

`default_nettype none

interface mpa_issue_if import mpa_pkg::*; ();

    logic                  valid;
    mpa_subclass_e         subclass;
    logic [MPA_IMM_W-1:0]  imm;
    logic [MPA_CPR_AW-1:0] crd;
    logic [MPA_XLEN-1:0]   rs1;
    logic [MPA_XLEN-1:0]   rs2;
    logic [MPA_XLEN-1:0]   rs3;
    logic [MPA_XLEN-1:0]   gpr;
    logic                  done;

    modport issue (
        output valid, subclass, imm, crd, rs1, rs2, rs3, gpr,
        input  done
    );

    modport alu (
        input  valid, subclass, imm, crd, rs1, rs2, rs3, gpr,
        output done
    );

endinterface

`default_nettype wire

// ==== verilog/mpa_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Multi-precision coprocessor package: instruction fields, subclass codes,
// step counts and register file sizes
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package mpa_pkg;

    // Word and register file sizes
    localparam int MPA_XLEN    = 32;
    localparam int MPA_DXLEN   = 2 * MPA_XLEN;
    localparam int MPA_NUM_CPR = 8;
    localparam int MPA_CPR_AW  = 3;

    // Instruction field widths
    localparam int MPA_SUBCLASS_W = 5;
    localparam int MPA_IMM_W      = 6;
    localparam int MPA_RSVD_W     = 9;
    localparam int MPA_STEP_W     = 2;

    typedef enum logic [MPA_SUBCLASS_W-1:0] {
        MPA_SC_MEQU     = 5'd0,
        MPA_SC_MLTE     = 5'd1,
        MPA_SC_MGTE     = 5'd2,
        MPA_SC_MADD_3   = 5'd3,
        MPA_SC_MADD_2   = 5'd4,
        MPA_SC_MSUB_3   = 5'd5,
        MPA_SC_MSUB_2   = 5'd6,
        MPA_SC_MSLL_I   = 5'd7,
        MPA_SC_MSLL     = 5'd8,
        MPA_SC_MSRL_I   = 5'd9,
        MPA_SC_MSRL     = 5'd10,
        MPA_SC_MACC_1   = 5'd11,
        MPA_SC_MMUL_1   = 5'd12,
        MPA_SC_MCLMUL_1 = 5'd13
    } mpa_subclass_e;

    // Subclass sits in the top bits of the word
    typedef struct packed {
        mpa_subclass_e         subclass;
        logic [MPA_CPR_AW-1:0] crd;
        logic [MPA_CPR_AW-1:0] crs1;
        logic [MPA_CPR_AW-1:0] crs2;
        logic [MPA_CPR_AW-1:0] crs3;
        logic [MPA_IMM_W-1:0]  imm;
        logic [MPA_RSVD_W-1:0] reserved;
    } mpa_instr_t;

    typedef logic [MPA_STEP_W-1:0] mpa_step_t;

    // Final step of each subclass; undefined codes finish in step 0
    localparam mpa_step_t MPA_LAST_STEP [2**MPA_SUBCLASS_W] = '{
        MPA_SC_MADD_2   : 2'd1,
        MPA_SC_MSUB_2   : 2'd1,
        MPA_SC_MACC_1   : 2'd1,
        MPA_SC_MSLL_I   : 2'd1,
        MPA_SC_MSLL     : 2'd1,
        MPA_SC_MSRL_I   : 2'd1,
        MPA_SC_MSRL     : 2'd1,
        MPA_SC_MCLMUL_1 : 2'd1,
        MPA_SC_MADD_3   : 2'd2,
        MPA_SC_MSUB_3   : 2'd2,
        MPA_SC_MMUL_1   : 2'd2,
        default         : 2'd0
    };

endpackage

`default_nettype wire
